// File: source/axil_pkg.sv
// AXI4-Lite bus widths, response codes and channel payload types shared by RTL and testbench
package axil_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    // one strobe bit per byte lane
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    typedef struct packed {
        addr_t addr;
    } aw_payload_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_payload_t;

    typedef struct packed {
        resp_t resp;
    } b_payload_t;

    typedef struct packed {
        addr_t addr;
    } ar_payload_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } r_payload_t;

endpackage

// File: source/axil_skid_buffer.sv
// two-entry register stage for one valid/ready channel, used once per channel by the register slice
`timescale 1ns/10ps

module axil_skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t main_data;
    payload_t skid_data;
    logic     main_valid;
    logic     skid_valid;
    logic     in_ready_reg;
    logic     in_xfer;
    logic     main_free;
    logic     main_valid_next;
    logic     skid_valid_next;

    assign in_xfer   = in_valid && in_ready_reg;
    // main register empties or hands its item on this cycle
    assign main_free = !main_valid || out_ready;

    assign in_ready  = in_ready_reg;
    assign out_data  = main_data;
    assign out_valid = main_valid;

    // skid only ever holds an item while main is full, so it never takes input when main frees
    always_comb begin
        if (main_free) begin
            main_valid_next = skid_valid || in_xfer;
            skid_valid_next = 1'b0;
        end else begin
            main_valid_next = 1'b1;
            skid_valid_next = skid_valid || in_xfer;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            main_data <= skid_valid ? skid_data : in_data;
        end else if (in_xfer) begin
            skid_data <= in_data;
        end

        if (rst) begin
            main_valid   <= 1'b0;
            skid_valid   <= 1'b0;
            in_ready_reg <= 1'b0;
        end else begin
            main_valid   <= main_valid_next;
            skid_valid   <= skid_valid_next;
            in_ready_reg <= !(main_valid_next && skid_valid_next);
        end
    end

endmodule

// File: source/axil_register_slice.sv
// AXI4-Lite register slice that puts one skid buffer on each of the five channels
`timescale 1ns/10ps

module axil_register_slice import axil_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    // upstream side, from the external master
    input  addr_t s_awaddr,
    input  logic  s_awvalid,
    output logic  s_awready,
    input  data_t s_wdata,
    input  strb_t s_wstrb,
    input  logic  s_wvalid,
    output logic  s_wready,
    output resp_t s_bresp,
    output logic  s_bvalid,
    input  logic  s_bready,
    input  addr_t s_araddr,
    input  logic  s_arvalid,
    output logic  s_arready,
    output data_t s_rdata,
    output resp_t s_rresp,
    output logic  s_rvalid,
    input  logic  s_rready,

    // downstream side, towards the decoder
    output addr_t m_awaddr,
    output logic  m_awvalid,
    input  logic  m_awready,
    output data_t m_wdata,
    output strb_t m_wstrb,
    output logic  m_wvalid,
    input  logic  m_wready,
    input  resp_t m_bresp,
    input  logic  m_bvalid,
    output logic  m_bready,
    output addr_t m_araddr,
    output logic  m_arvalid,
    input  logic  m_arready,
    input  data_t m_rdata,
    input  resp_t m_rresp,
    input  logic  m_rvalid,
    output logic  m_rready
);

    aw_payload_t aw_in, aw_out;
    w_payload_t  w_in, w_out;
    b_payload_t  b_in, b_out;
    ar_payload_t ar_in, ar_out;
    r_payload_t  r_in, r_out;

    // forward channels
    assign aw_in.addr = s_awaddr;
    assign m_awaddr   = aw_out.addr;
    assign w_in.data  = s_wdata;
    assign w_in.strb  = s_wstrb;
    assign m_wdata    = w_out.data;
    assign m_wstrb    = w_out.strb;
    assign ar_in.addr = s_araddr;
    assign m_araddr   = ar_out.addr;

    // response channels run the other way
    assign b_in.resp  = m_bresp;
    assign s_bresp    = b_out.resp;
    assign r_in.data  = m_rdata;
    assign r_in.resp  = m_rresp;
    assign s_rdata    = r_out.data;
    assign s_rresp    = r_out.resp;

    axil_skid_buffer #(.payload_t(aw_payload_t)) aw_skid (
        .clk(clk), .rst(rst),
        .in_data(aw_in), .in_valid(s_awvalid), .in_ready(s_awready),
        .out_data(aw_out), .out_valid(m_awvalid), .out_ready(m_awready)
    );

    axil_skid_buffer #(.payload_t(w_payload_t)) w_skid (
        .clk(clk), .rst(rst),
        .in_data(w_in), .in_valid(s_wvalid), .in_ready(s_wready),
        .out_data(w_out), .out_valid(m_wvalid), .out_ready(m_wready)
    );

    axil_skid_buffer #(.payload_t(b_payload_t)) b_skid (
        .clk(clk), .rst(rst),
        .in_data(b_in), .in_valid(m_bvalid), .in_ready(m_bready),
        .out_data(b_out), .out_valid(s_bvalid), .out_ready(s_bready)
    );

    axil_skid_buffer #(.payload_t(ar_payload_t)) ar_skid (
        .clk(clk), .rst(rst),
        .in_data(ar_in), .in_valid(s_arvalid), .in_ready(s_arready),
        .out_data(ar_out), .out_valid(m_arvalid), .out_ready(m_arready)
    );

    axil_skid_buffer #(.payload_t(r_payload_t)) r_skid (
        .clk(clk), .rst(rst),
        .in_data(r_in), .in_valid(m_rvalid), .in_ready(m_rready),
        .out_data(r_out), .out_valid(s_rvalid), .out_ready(s_rready)
    );

endmodule

// File: source/axil_ram.sv
// AXI4-Lite RAM with per-byte write strobes and an optional extra register on read data
`timescale 1ns/10ps

module axil_ram import axil_pkg::*; #(
    parameter int RAM_ADDR_W      = 10,
    parameter bit PIPELINE_OUTPUT = 1'b0
) (
    input  logic  clk,
    input  logic  rst,
    input  addr_t s_awaddr,
    input  logic  s_awvalid,
    output logic  s_awready,
    input  data_t s_wdata,
    input  strb_t s_wstrb,
    input  logic  s_wvalid,
    output logic  s_wready,
    output resp_t s_bresp,
    output logic  s_bvalid,
    input  logic  s_bready,
    input  addr_t s_araddr,
    input  logic  s_arvalid,
    output logic  s_arready,
    output data_t s_rdata,
    output resp_t s_rresp,
    output logic  s_rvalid,
    input  logic  s_rready
);

    localparam int LANE_LSB = $clog2(STRB_W);
    localparam int WORD_W   = RAM_ADDR_W - LANE_LSB;
    localparam int DEPTH    = 2 ** WORD_W;
    localparam int BYTE_W   = DATA_W / STRB_W;

    data_t mem [0:DEPTH-1];

    logic [WORD_W-1:0] wr_index;
    logic [WORD_W-1:0] rd_index;

    logic  mem_wr_en;
    logic  mem_rd_en;
    logic  awready_reg;
    logic  wready_reg;
    logic  bvalid_reg;
    logic  arready_reg;
    logic  rvalid_reg;
    data_t rdata_reg;
    logic  rvalid_pipe;
    data_t rdata_pipe;
    logic  stage_drain;

    // byte address to word index
    assign wr_index = s_awaddr[RAM_ADDR_W-1:LANE_LSB];
    assign rd_index = s_araddr[RAM_ADDR_W-1:LANE_LSB];

    assign s_awready = awready_reg;
    assign s_wready  = wready_reg;
    assign s_bresp   = RESP_OKAY;
    assign s_bvalid  = bvalid_reg;

    assign s_arready = arready_reg;
    assign s_rdata   = PIPELINE_OUTPUT ? rdata_pipe : rdata_reg;
    assign s_rresp   = RESP_OKAY;
    assign s_rvalid  = PIPELINE_OUTPUT ? rvalid_pipe : rvalid_reg;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // write needs both channels and room for the response
    // the ready pulse from the last accept blocks a repeat on the same beat
    assign mem_wr_en = s_awvalid && s_wvalid && (!bvalid_reg || s_bready)
                       && !awready_reg && !wready_reg;

    always_ff @(posedge clk) begin
        for (int i = 0; i < STRB_W; i++) begin
            if (mem_wr_en && s_wstrb[i]) begin
                mem[wr_index][BYTE_W*i +: BYTE_W] <= s_wdata[BYTE_W*i +: BYTE_W];
            end
        end

        if (rst) begin
            awready_reg <= 1'b0;
            wready_reg  <= 1'b0;
            bvalid_reg  <= 1'b0;
        end else begin
            awready_reg <= mem_wr_en;
            wready_reg  <= mem_wr_en;
            bvalid_reg  <= mem_wr_en || (bvalid_reg && !s_bready);
        end
    end

    // first read stage empties into the output, or into the pipe stage when present
    assign stage_drain = PIPELINE_OUTPUT ? (!rvalid_pipe || s_rready) : s_rready;
    assign mem_rd_en   = s_arvalid && (!rvalid_reg || stage_drain) && !arready_reg;

    always_ff @(posedge clk) begin
        if (mem_rd_en) begin
            rdata_reg <= mem[rd_index];
        end

        if (!rvalid_pipe || s_rready) begin
            rdata_pipe <= rdata_reg;
        end

        if (rst) begin
            arready_reg <= 1'b0;
            rvalid_reg  <= 1'b0;
            rvalid_pipe <= 1'b0;
        end else begin
            arready_reg <= mem_rd_en;
            rvalid_reg  <= mem_rd_en || (rvalid_reg && !stage_drain);
            if (!rvalid_pipe || s_rready) begin
                rvalid_pipe <= rvalid_reg;
            end
        end
    end

endmodule

// File: source/axil_address_decoder.sv
// splits the AXI4-Lite address space over two RAM ports and answers unmapped accesses itself
`timescale 1ns/10ps

module axil_address_decoder import axil_pkg::*; #(
    parameter int RAM_ADDR_W = 10
) (
    input  logic  clk,
    input  logic  rst,
    input  addr_t s_awaddr,
    input  logic  s_awvalid,
    output logic  s_awready,
    input  data_t s_wdata,
    input  strb_t s_wstrb,
    input  logic  s_wvalid,
    output logic  s_wready,
    output resp_t s_bresp,
    output logic  s_bvalid,
    input  logic  s_bready,
    input  addr_t s_araddr,
    input  logic  s_arvalid,
    output logic  s_arready,
    output data_t s_rdata,
    output resp_t s_rresp,
    output logic  s_rvalid,
    input  logic  s_rready,
    output addr_t m0_awaddr,
    output logic  m0_awvalid,
    input  logic  m0_awready,
    output data_t m0_wdata,
    output strb_t m0_wstrb,
    output logic  m0_wvalid,
    input  logic  m0_wready,
    input  resp_t m0_bresp,
    input  logic  m0_bvalid,
    output logic  m0_bready,
    output addr_t m0_araddr,
    output logic  m0_arvalid,
    input  logic  m0_arready,
    input  data_t m0_rdata,
    input  resp_t m0_rresp,
    input  logic  m0_rvalid,
    output logic  m0_rready,
    output addr_t m1_awaddr,
    output logic  m1_awvalid,
    input  logic  m1_awready,
    output data_t m1_wdata,
    output strb_t m1_wstrb,
    output logic  m1_wvalid,
    input  logic  m1_wready,
    input  resp_t m1_bresp,
    input  logic  m1_bvalid,
    output logic  m1_bready,
    output addr_t m1_araddr,
    output logic  m1_arvalid,
    input  logic  m1_arready,
    input  data_t m1_rdata,
    input  resp_t m1_rresp,
    input  logic  m1_rvalid,
    output logic  m1_rready
);

    localparam addr_t OFFSET_MASK = addr_t'((1 << RAM_ADDR_W) - 1);

    // ST_ERR is the wait cycle before a locally generated decode error
    typedef enum logic [1:0] {ST_IDLE, ST_FWD, ST_ERR, ST_ERR_RESP} state_t;

    state_t wr_state, rd_state;
    addr_t  aw_region, ar_region;
    addr_t  wr_addr, rd_addr;
    data_t  wr_data;
    strb_t  wr_strb;
    logic   wr_sel, rd_sel;
    logic   aw_pend, w_pend, ar_pend;
    logic   wr_accept, rd_accept;
    logic   wr_fwd, rd_fwd;

    assign aw_region = s_awaddr >> RAM_ADDR_W;
    assign ar_region = s_araddr >> RAM_ADDR_W;

    // write side: aw and w are taken together, one transaction at a time
    assign wr_accept = (wr_state == ST_IDLE) && s_awvalid && s_wvalid;
    assign wr_fwd    = (wr_state == ST_FWD);
    assign s_awready = wr_accept;
    assign s_wready  = wr_accept;

    assign m0_awaddr  = wr_addr;
    assign m1_awaddr  = wr_addr;
    assign m0_wdata   = wr_data;
    assign m1_wdata   = wr_data;
    assign m0_wstrb   = wr_strb;
    assign m1_wstrb   = wr_strb;
    assign m0_awvalid = wr_fwd && aw_pend && !wr_sel;
    assign m1_awvalid = wr_fwd && aw_pend && wr_sel;
    assign m0_wvalid  = wr_fwd && w_pend && !wr_sel;
    assign m1_wvalid  = wr_fwd && w_pend && wr_sel;
    assign m0_bready  = wr_fwd && !wr_sel && s_bready;
    assign m1_bready  = wr_fwd && wr_sel && s_bready;

    assign s_bvalid = (wr_state == ST_ERR_RESP) || (wr_fwd && (wr_sel ? m1_bvalid : m0_bvalid));
    assign s_bresp  = (wr_state == ST_ERR_RESP) ? RESP_DECERR : (wr_sel ? m1_bresp : m0_bresp);

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            wr_addr <= s_awaddr & OFFSET_MASK;
            wr_data <= s_wdata;
            wr_strb <= s_wstrb;
            wr_sel  <= aw_region[0];
        end

        if (rst) begin
            wr_state <= ST_IDLE;
            aw_pend  <= 1'b0;
            w_pend   <= 1'b0;
        end else begin
            case (wr_state)
                ST_IDLE: begin
                    if (wr_accept) begin
                        wr_state <= (aw_region < 2) ? ST_FWD : ST_ERR;
                        aw_pend  <= (aw_region < 2);
                        w_pend   <= (aw_region < 2);
                    end
                end
                ST_FWD: begin
                    if (wr_sel ? m1_awready : m0_awready) begin
                        aw_pend <= 1'b0;
                    end
                    if (wr_sel ? m1_wready : m0_wready) begin
                        w_pend <= 1'b0;
                    end
                    if (s_bvalid && s_bready) begin
                        wr_state <= ST_IDLE;
                    end
                end
                ST_ERR:      wr_state <= ST_ERR_RESP;
                ST_ERR_RESP: if (s_bready) wr_state <= ST_IDLE;
                default:     wr_state <= ST_IDLE;
            endcase
        end
    end

    // read side mirrors the write side
    assign rd_accept = (rd_state == ST_IDLE) && s_arvalid;
    assign rd_fwd    = (rd_state == ST_FWD);
    assign s_arready = rd_accept;

    assign m0_araddr  = rd_addr;
    assign m1_araddr  = rd_addr;
    assign m0_arvalid = rd_fwd && ar_pend && !rd_sel;
    assign m1_arvalid = rd_fwd && ar_pend && rd_sel;
    assign m0_rready  = rd_fwd && !rd_sel && s_rready;
    assign m1_rready  = rd_fwd && rd_sel && s_rready;

    assign s_rvalid = (rd_state == ST_ERR_RESP) || (rd_fwd && (rd_sel ? m1_rvalid : m0_rvalid));
    assign s_rresp  = (rd_state == ST_ERR_RESP) ? RESP_DECERR : (rd_sel ? m1_rresp : m0_rresp);
    assign s_rdata  = (rd_state == ST_ERR_RESP) ? '0 : (rd_sel ? m1_rdata : m0_rdata);

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_addr <= s_araddr & OFFSET_MASK;
            rd_sel  <= ar_region[0];
        end

        if (rst) begin
            rd_state <= ST_IDLE;
            ar_pend  <= 1'b0;
        end else begin
            case (rd_state)
                ST_IDLE: begin
                    if (rd_accept) begin
                        rd_state <= (ar_region < 2) ? ST_FWD : ST_ERR;
                        ar_pend  <= (ar_region < 2);
                    end
                end
                ST_FWD: begin
                    if (rd_sel ? m1_arready : m0_arready) begin
                        ar_pend <= 1'b0;
                    end
                    if (s_rvalid && s_rready) begin
                        rd_state <= ST_IDLE;
                    end
                end
                ST_ERR:      rd_state <= ST_ERR_RESP;
                ST_ERR_RESP: if (s_rready) rd_state <= ST_IDLE;
                default:     rd_state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: source/axil_mem_subsystem.sv
// top level of the AXI4-Lite memory block: register slice, address decoder and two RAMs
`timescale 1ns/10ps

module axil_mem_subsystem import axil_pkg::*; #(
    parameter int RAM_ADDR_W      = 10,
    parameter bit PIPELINE_OUTPUT = 1'b0
) (
    input  logic  clk,
    input  logic  rst,
    input  addr_t s_awaddr,
    input  logic  s_awvalid,
    output logic  s_awready,
    input  data_t s_wdata,
    input  strb_t s_wstrb,
    input  logic  s_wvalid,
    output logic  s_wready,
    output resp_t s_bresp,
    output logic  s_bvalid,
    input  logic  s_bready,
    input  addr_t s_araddr,
    input  logic  s_arvalid,
    output logic  s_arready,
    output data_t s_rdata,
    output resp_t s_rresp,
    output logic  s_rvalid,
    input  logic  s_rready
);

    // slice to decoder
    addr_t dec_awaddr, dec_araddr;
    data_t dec_wdata, dec_rdata;
    strb_t dec_wstrb;
    resp_t dec_bresp, dec_rresp;
    logic  dec_awvalid, dec_awready, dec_wvalid, dec_wready, dec_bvalid, dec_bready;
    logic  dec_arvalid, dec_arready, dec_rvalid, dec_rready;

    // decoder to the two RAMs
    addr_t ram0_awaddr, ram0_araddr, ram1_awaddr, ram1_araddr;
    data_t ram0_wdata, ram0_rdata, ram1_wdata, ram1_rdata;
    strb_t ram0_wstrb, ram1_wstrb;
    resp_t ram0_bresp, ram0_rresp, ram1_bresp, ram1_rresp;
    logic  ram0_awvalid, ram0_awready, ram0_wvalid, ram0_wready, ram0_bvalid, ram0_bready;
    logic  ram0_arvalid, ram0_arready, ram0_rvalid, ram0_rready;
    logic  ram1_awvalid, ram1_awready, ram1_wvalid, ram1_wready, ram1_bvalid, ram1_bready;
    logic  ram1_arvalid, ram1_arready, ram1_rvalid, ram1_rready;

    axil_register_slice slice (
        .clk(clk), .rst(rst),
        .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .m_awaddr(dec_awaddr), .m_awvalid(dec_awvalid), .m_awready(dec_awready),
        .m_wdata(dec_wdata), .m_wstrb(dec_wstrb), .m_wvalid(dec_wvalid),
        .m_wready(dec_wready),
        .m_bresp(dec_bresp), .m_bvalid(dec_bvalid), .m_bready(dec_bready),
        .m_araddr(dec_araddr), .m_arvalid(dec_arvalid), .m_arready(dec_arready),
        .m_rdata(dec_rdata), .m_rresp(dec_rresp), .m_rvalid(dec_rvalid),
        .m_rready(dec_rready)
    );

    axil_address_decoder #(.RAM_ADDR_W(RAM_ADDR_W)) decoder (
        .clk(clk), .rst(rst),
        .s_awaddr(dec_awaddr), .s_awvalid(dec_awvalid), .s_awready(dec_awready),
        .s_wdata(dec_wdata), .s_wstrb(dec_wstrb), .s_wvalid(dec_wvalid),
        .s_wready(dec_wready),
        .s_bresp(dec_bresp), .s_bvalid(dec_bvalid), .s_bready(dec_bready),
        .s_araddr(dec_araddr), .s_arvalid(dec_arvalid), .s_arready(dec_arready),
        .s_rdata(dec_rdata), .s_rresp(dec_rresp), .s_rvalid(dec_rvalid),
        .s_rready(dec_rready),
        .m0_awaddr(ram0_awaddr), .m0_awvalid(ram0_awvalid), .m0_awready(ram0_awready),
        .m0_wdata(ram0_wdata), .m0_wstrb(ram0_wstrb), .m0_wvalid(ram0_wvalid),
        .m0_wready(ram0_wready),
        .m0_bresp(ram0_bresp), .m0_bvalid(ram0_bvalid), .m0_bready(ram0_bready),
        .m0_araddr(ram0_araddr), .m0_arvalid(ram0_arvalid), .m0_arready(ram0_arready),
        .m0_rdata(ram0_rdata), .m0_rresp(ram0_rresp), .m0_rvalid(ram0_rvalid),
        .m0_rready(ram0_rready),
        .m1_awaddr(ram1_awaddr), .m1_awvalid(ram1_awvalid), .m1_awready(ram1_awready),
        .m1_wdata(ram1_wdata), .m1_wstrb(ram1_wstrb), .m1_wvalid(ram1_wvalid),
        .m1_wready(ram1_wready),
        .m1_bresp(ram1_bresp), .m1_bvalid(ram1_bvalid), .m1_bready(ram1_bready),
        .m1_araddr(ram1_araddr), .m1_arvalid(ram1_arvalid), .m1_arready(ram1_arready),
        .m1_rdata(ram1_rdata), .m1_rresp(ram1_rresp), .m1_rvalid(ram1_rvalid),
        .m1_rready(ram1_rready)
    );

    axil_ram #(.RAM_ADDR_W(RAM_ADDR_W), .PIPELINE_OUTPUT(PIPELINE_OUTPUT)) ram0 (
        .clk(clk), .rst(rst),
        .s_awaddr(ram0_awaddr), .s_awvalid(ram0_awvalid), .s_awready(ram0_awready),
        .s_wdata(ram0_wdata), .s_wstrb(ram0_wstrb), .s_wvalid(ram0_wvalid),
        .s_wready(ram0_wready),
        .s_bresp(ram0_bresp), .s_bvalid(ram0_bvalid), .s_bready(ram0_bready),
        .s_araddr(ram0_araddr), .s_arvalid(ram0_arvalid), .s_arready(ram0_arready),
        .s_rdata(ram0_rdata), .s_rresp(ram0_rresp), .s_rvalid(ram0_rvalid),
        .s_rready(ram0_rready)
    );

    axil_ram #(.RAM_ADDR_W(RAM_ADDR_W), .PIPELINE_OUTPUT(PIPELINE_OUTPUT)) ram1 (
        .clk(clk), .rst(rst),
        .s_awaddr(ram1_awaddr), .s_awvalid(ram1_awvalid), .s_awready(ram1_awready),
        .s_wdata(ram1_wdata), .s_wstrb(ram1_wstrb), .s_wvalid(ram1_wvalid),
        .s_wready(ram1_wready),
        .s_bresp(ram1_bresp), .s_bvalid(ram1_bvalid), .s_bready(ram1_bready),
        .s_araddr(ram1_araddr), .s_arvalid(ram1_arvalid), .s_arready(ram1_arready),
        .s_rdata(ram1_rdata), .s_rresp(ram1_rresp), .s_rvalid(ram1_rvalid),
        .s_rready(ram1_rready)
    );

endmodule

// File: testbench/tb_axil_mem_subsystem.sv
// random-stimulus testbench for the AXI4-Lite memory subsystem, compiled as the simulation top
`timescale 1ns/10ps

module tb_axil_mem_subsystem import axil_pkg::*; ();

    localparam int RAM_ADDR_W   = 10;
    localparam int REGION_BYTES = 1 << RAM_ADDR_W;
    localparam int MAPPED_BYTES = 2 * REGION_BYTES;

    // transaction counts per test, also used to size the timeout
    localparam int RESET_READS    = 16;
    localparam int WORD_WRITES    = 100;
    localparam int STRB_WRITES    = 100;
    localparam int SEP_OFFSETS    = 8;
    localparam int ERR_ACCESSES   = 10;
    localparam int STRESS_TXNS    = 40;
    localparam int TOTAL_TXNS     = RESET_READS + 2 * WORD_WRITES + 2 * STRB_WRITES
                                    + 4 * SEP_OFFSETS + 3 * ERR_ACCESSES + 2 * STRESS_TXNS;
    localparam int CYCLES_PER_TXN = 40;
    localparam int TIMEOUT_CYCLES = TOTAL_TXNS * CYCLES_PER_TXN + 100;

    logic  clk;
    logic  rst;
    addr_t s_awaddr;
    logic  s_awvalid;
    logic  s_awready;
    data_t s_wdata;
    strb_t s_wstrb;
    logic  s_wvalid;
    logic  s_wready;
    resp_t s_bresp;
    logic  s_bvalid;
    logic  s_bready;
    addr_t s_araddr;
    logic  s_arvalid;
    logic  s_arready;
    data_t s_rdata;
    resp_t s_rresp;
    logic  s_rvalid;
    logic  s_rready;

    // byte-wide reference memory for both regions
    logic [7:0] model_mem [0:MAPPED_BYTES-1];

    string test_name;
    int    pass_count;
    int    fail_count;
    int    test_pass_start;
    int    test_fail_start;
    int    wr_issued;
    int    rd_issued;
    int    b_seen;
    int    r_seen;
    int    cycle_count;

    axil_mem_subsystem #(.RAM_ADDR_W(RAM_ADDR_W), .PIPELINE_OUTPUT(1'b1)) uut (
        .clk(clk), .rst(rst),
        .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready)
    );

    always #4 clk = ~clk;

    // completed transactions as seen on the bus, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && s_bvalid && s_bready) begin
            b_seen++;
        end
        if (!rst && s_rvalid && s_rready) begin
            r_seen++;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_value(input string what, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // all drives and samples happen 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        test_pass_start = pass_count;
        test_fail_start = fail_count;
    endtask

    task automatic report_test();
        $display("test %s done: %0d checks, %0d errors", test_name,
                 pass_count + fail_count - test_pass_start - test_fail_start,
                 fail_count - test_fail_start);
    endtask

    function automatic data_t model_read(input addr_t addr);
        data_t word;
        int    base;
        word = '0;
        base = int'(addr) & ~3;
        if (base < MAPPED_BYTES) begin
            for (int i = 0; i < STRB_W; i++) begin
                word[8*i +: 8] = model_mem[base + i];
            end
        end
        return word;
    endfunction

    function automatic void model_write(input addr_t addr, input data_t data, input strb_t strb);
        int base;
        base = int'(addr) & ~3;
        if (base < MAPPED_BYTES) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (strb[i]) begin
                    model_mem[base + i] = data[8*i +: 8];
                end
            end
        end
    endfunction

    function automatic resp_t model_resp(input addr_t addr);
        return (int'(addr) < MAPPED_BYTES) ? RESP_OKAY : RESP_DECERR;
    endfunction

    function automatic addr_t region_addr(input int region, input int words);
        return addr_t'(region * REGION_BYTES + 4 * $urandom_range(words - 1, 0));
    endfunction

    function automatic addr_t unmapped_addr();
        return addr_t'(MAPPED_BYTES + ($urandom_range(65535 - MAPPED_BYTES, 0) & ~3));
    endfunction

    task automatic write_txn(input addr_t addr, input data_t data, input strb_t strb,
                             output resp_t resp);
        int stall;
        bit aw_done;
        bit w_done;
        stall   = $urandom_range(3, 0);
        aw_done = 1'b0;
        w_done  = 1'b0;
        wr_issued++;
        s_awaddr  = addr;
        s_awvalid = 1'b1;
        s_wdata   = data;
        s_wstrb   = strb;
        s_wvalid  = 1'b1;
        // aw and w may be taken on different edges
        while (!(aw_done && w_done)) begin
            if (s_awvalid && s_awready) aw_done = 1'b1;
            if (s_wvalid && s_wready) w_done = 1'b1;
            next_cycle();
            if (aw_done) s_awvalid = 1'b0;
            if (w_done) s_wvalid = 1'b0;
        end
        repeat (stall) next_cycle();
        s_bready = 1'b1;
        while (!s_bvalid) next_cycle();
        resp = s_bresp;
        next_cycle();
        s_bready = 1'b0;
    endtask

    task automatic read_txn(input addr_t addr, output data_t data, output resp_t resp);
        int stall;
        stall = $urandom_range(3, 0);
        rd_issued++;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        while (!s_arready) next_cycle();
        next_cycle();
        s_arvalid = 1'b0;
        repeat (stall) next_cycle();
        s_rready = 1'b1;
        while (!s_rvalid) next_cycle();
        data = s_rdata;
        resp = s_rresp;
        next_cycle();
        s_rready = 1'b0;
    endtask

    task automatic write_and_check(input addr_t addr, input data_t data, input strb_t strb);
        resp_t resp;
        write_txn(addr, data, strb, resp);
        check_value("bresp", model_resp(addr), resp);
        model_write(addr, data, strb);
    endtask

    task automatic read_and_check(input addr_t addr);
        data_t data;
        resp_t resp;
        read_txn(addr, data, resp);
        check_value("rdata", model_read(addr), data);
        check_value("rresp", model_resp(addr), resp);
    endtask

    initial begin
        addr_t addr_list[$];
        addr_t addr;
        data_t data;
        data_t rd_data;
        resp_t rd_resp;

        clk       = 1'b0;
        rst       = 1'b1;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        pass_count = 0;
        fail_count = 0;
        wr_issued  = 0;
        rd_issued  = 0;
        b_seen     = 0;
        r_seen     = 0;
        for (int i = 0; i < MAPPED_BYTES; i++) begin
            model_mem[i] = 8'h00;
        end
        void'($urandom(32'h9ae7c067));

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();

        start_test("reset_state");
        for (int i = 0; i < RESET_READS; i++) begin
            read_txn(region_addr(i % 2, REGION_BYTES / 4), rd_data, rd_resp);
            check_value("rdata", 32'h0, rd_data);
            check_value("rresp", RESP_OKAY, rd_resp);
        end
        report_test();

        start_test("word_write");
        for (int i = 0; i < WORD_WRITES; i++) begin
            addr = region_addr($urandom_range(1, 0), REGION_BYTES / 4);
            addr_list.push_back(addr);
            write_and_check(addr, $urandom(), 4'hf);
        end
        while (addr_list.size() > 0) begin
            read_and_check(addr_list.pop_front());
        end
        report_test();

        // a small address pool so partial writes land on the same words
        start_test("byte_strobe");
        for (int i = 0; i < STRB_WRITES; i++) begin
            addr = region_addr($urandom_range(1, 0), 32);
            addr_list.push_back(addr);
            write_and_check(addr, $urandom(), strb_t'($urandom_range(15, 0)));
        end
        while (addr_list.size() > 0) begin
            read_and_check(addr_list.pop_front());
        end
        report_test();

        start_test("region_separation");
        for (int i = 0; i < SEP_OFFSETS; i++) begin
            addr = region_addr(0, REGION_BYTES / 4);
            data = $urandom();
            write_and_check(addr, data, 4'hf);
            write_and_check(addr + addr_t'(REGION_BYTES), ~data, 4'hf);
            read_and_check(addr);
            read_and_check(addr + addr_t'(REGION_BYTES));
        end
        report_test();

        start_test("decode_error");
        for (int i = 0; i < ERR_ACCESSES; i++) begin
            addr = unmapped_addr();
            addr_list.push_back(addr);
            write_and_check(addr, $urandom(), 4'hf);
            read_and_check(unmapped_addr());
        end
        // the aliased mapped word must still hold its old value
        while (addr_list.size() > 0) begin
            addr = addr_list.pop_front();
            read_and_check(addr % addr_t'(MAPPED_BYTES));
        end
        report_test();

        // writes to ram0 and reads from ram1 run side by side
        start_test("back_pressure");
        fork
            begin
                for (int i = 0; i < STRESS_TXNS; i++) begin
                    write_and_check(region_addr(0, REGION_BYTES / 4), $urandom(),
                                    strb_t'($urandom_range(15, 0)));
                end
            end
            begin
                for (int i = 0; i < STRESS_TXNS; i++) begin
                    read_and_check(region_addr(1, REGION_BYTES / 4));
                end
            end
        join
        repeat (10) next_cycle();
        check_value("writes completed", wr_issued, b_seen);
        check_value("reads completed", rd_issued, r_seen);
        check_value("stray bvalid", 1'b0, s_bvalid);
        check_value("stray rvalid", 1'b0, s_rvalid);
        report_test();

        $display("totals: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
source/axil_pkg.sv
source/axil_skid_buffer.sv
source/axil_register_slice.sv
source/axil_ram.sv
source/axil_address_decoder.sv
source/axil_mem_subsystem.sv
testbench/tb_axil_mem_subsystem.sv

// File: Bender.yml
package:
  name: axil_mem_subsystem

sources:
  - source/axil_pkg.sv
  - source/axil_skid_buffer.sv
  - source/axil_register_slice.sv
  - source/axil_ram.sv
  - source/axil_address_decoder.sv
  - source/axil_mem_subsystem.sv
  - target: test
    files:
      - testbench/tb_axil_mem_subsystem.sv
